//--- sdmac_params.svh
`ifndef SDMAC_PARAMS_SVH
`define SDMAC_PARAMS_SVH

// Host and memory data width
`define SDMAC_DATA_W     32

// Transfer byte count width
`define SDMAC_COUNT_W    24

// Words held in the packing FIFO
`define SDMAC_FIFO_DEPTH 4

// Register word offsets seen from the host
`define REG_CONTROL      3'd0
`define REG_STATUS       3'd1
`define REG_ADDRESS      3'd2
`define REG_COUNT        3'd3
`define REG_ISTR_CLR     3'd4

`endif

//--- sdmacPkg.sv
`include "sdmac_params.svh"

package sdmacPkg;

    typedef logic [`SDMAC_DATA_W-1:0]  dataWordT;
    typedef logic [7:0]                byteT;
    typedef logic [`SDMAC_COUNT_W-1:0] countT;
    typedef logic [2:0]                regAddrT;

    // Lane 0 is the most significant byte, bits 31 to 24
    typedef logic [1:0]                byteOffT;

    // Peripheral port byte cycle
    typedef enum logic [1:0] {
        SCSI_IDLE,
        SCSI_STROBE1,
        SCSI_STROBE2,
        SCSI_RECOVER
    } scsiStateT;

    // Bus master arbitration and word cycles
    typedef enum logic [2:0] {
        BUS_IDLE,
        BUS_REQUEST,
        BUS_OWN,    // Bus held, between words
        BUS_STROBE, // Address strobe out, waiting for ack
        BUS_RELEASE,
        BUS_ERROR
    } busStateT;

endpackage

//--- sdmacRegisters.sv
`timescale 1ns/1ns
`include "sdmac_params.svh"

module sdmacRegisters import sdmacPkg::*; (
    input  logic     QnCPUCLK,
    input  logic     rst_i,
    input  logic     regCs_i,
    input  logic     regWr_i,
    input  regAddrT  regAddr_i,
    input  dataWordT regWdata_i,
    output dataWordT regRdata_o,
    output logic     regAck_o,
    input  logic     scsiInt_i,
    input  logic     done_i,
    input  logic     busError_i,
    input  logic     fifoEmpty_i,
    input  logic     busy_i,
    output logic     dmaEnable_o,
    output logic     dmaDir_o,
    output dataWordT startAddr_o,
    output countT    startCount_o,
    output logic     startPulse_o,
    output logic     int_o
);

    logic     intEnable;
    logic     doneFlag;    // Sticky
    logic     errorFlag;   // Sticky
    logic     intPending;
    logic     accept;      // New cycle taken on this edge
    logic     wrCycle;
    logic     ctrlWrite;
    logic     clrWrite;
    dataWordT readMux;

    assign accept    = regCs_i & ~regAck_o;
    assign wrCycle   = accept & regWr_i;
    assign ctrlWrite = wrCycle && (regAddr_i == `REG_CONTROL);
    assign clrWrite  = wrCycle && (regAddr_i == `REG_ISTR_CLR);

    always_comb begin
        readMux = '0;
        case (regAddr_i)
            `REG_CONTROL: readMux = {29'd0, intEnable, dmaDir_o, dmaEnable_o};
            `REG_STATUS:  readMux = {27'd0, busy_i, fifoEmpty_i, scsiInt_i, errorFlag, doneFlag};
            `REG_ADDRESS: readMux = startAddr_o;
            `REG_COUNT:   readMux = {{(`SDMAC_DATA_W - `SDMAC_COUNT_W){1'b0}}, startCount_o};
            default:      readMux = '0;
        endcase
    end

    always_ff @(posedge QnCPUCLK) begin
        if (rst_i) begin
            regAck_o     <= 1'b0;
            startPulse_o <= 1'b0;
            dmaEnable_o  <= 1'b0;
            dmaDir_o     <= 1'b0;
            intEnable    <= 1'b0;
            startAddr_o  <= '0;
            startCount_o <= '0;
        end else begin
            regAck_o     <= accept;
            startPulse_o <= ctrlWrite & regWdata_i[0]; // Enable bit starts a transfer
            if (wrCycle) begin
                case (regAddr_i)
                    `REG_CONTROL: begin
                        dmaEnable_o <= regWdata_i[0];
                        dmaDir_o    <= regWdata_i[1];  // 1 = memory to SCSI
                        intEnable   <= regWdata_i[2];
                    end
                    `REG_ADDRESS: startAddr_o <= regWdata_i;
                    `REG_COUNT:   startCount_o <= regWdata_i[`SDMAC_COUNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data lines up with the acknowledge
    always_ff @(posedge QnCPUCLK) begin
        if (accept) regRdata_o <= readMux;
    end

    always_ff @(posedge QnCPUCLK) begin
        if (rst_i) begin
            doneFlag   <= 1'b0;
            errorFlag  <= 1'b0;
            intPending <= 1'b0;
        end else begin
            if (clrWrite || ctrlWrite) doneFlag <= 1'b0;
            else if (done_i)           doneFlag <= 1'b1;
            if (clrWrite || ctrlWrite) errorFlag <= 1'b0;
            else if (busError_i)       errorFlag <= 1'b1;
            if (clrWrite)
                intPending <= 1'b0;
            else if ((done_i || busError_i) && intEnable)
                intPending <= 1'b1;
        end
    end

    assign int_o = intPending | scsiInt_i; // Chip interrupt passes straight out

    // Host holds chip select until it sees the ack, so a second ack would double a write
    assert property (@(posedge QnCPUCLK) disable iff (rst_i) regAck_o |=> !regAck_o);

endmodule

//--- dmaFifo.sv
`timescale 1ns/1ns

module dmaFifo import sdmacPkg::*; #(
    parameter int Depth = 4
) (
    input  logic     QnCPUCLK,
    input  logic     rst_i,
    input  logic     clear_i,
    input  logic     byteWr_i,
    input  byteT     byteIn_i,
    input  logic     byteRd_i,
    output byteT     byteOut_o,
    input  logic     wordWr_i,
    input  dataWordT wordIn_i,
    input  logic     wordRd_i,
    output dataWordT wordOut_o,
    output logic     canTakeByte_o,
    output logic     hasByte_o,
    output logic     hasWord_o,
    output logic     hasSpaceWord_o,
    output logic     empty_o
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    dataWordT        mem [Depth];
    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] wordCount;
    byteOffT         lane;       // Next byte lane on the SCSI side
    dataWordT        packWord;   // Lanes 0 to 2 of an incoming word
    dataWordT        pushData;
    logic            push;
    logic            pop;
    logic            full;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (wordCount == CntW'(Depth));
    assign push     = wordWr_i | (byteWr_i & (lane == 2'd3));
    assign pop      = wordRd_i | (byteRd_i & (lane == 2'd3));
    assign pushData = wordWr_i ? wordIn_i : {packWord[31:8], byteIn_i};

    assign wordOut_o = mem[rdPtr];
    assign byteOut_o = wordOut_o[{~lane, 3'b000} +: 8]; // MSB first

    always_ff @(posedge QnCPUCLK) begin
        if (push) mem[wrPtr] <= pushData;
        if (byteWr_i) packWord[{~lane, 3'b000} +: 8] <= byteIn_i;
    end

    always_ff @(posedge QnCPUCLK) begin
        if (rst_i || clear_i) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            wordCount <= '0;
            lane      <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop)  rdPtr <= nextPtr(rdPtr);
            if (push && !pop)
                wordCount <= wordCount + 1'b1;
            else if (pop && !push)
                wordCount <= wordCount - 1'b1;
            if (byteWr_i || byteRd_i) lane <= lane + 1'b1;
        end
    end

    assign canTakeByte_o  = ~full;
    assign hasByte_o      = (wordCount != '0);
    assign hasWord_o      = (wordCount != '0);
    assign hasSpaceWord_o = ~full;
    assign empty_o        = (wordCount == '0) && (lane == 2'd0);

    // Both port machines must check the flags before they commit a cycle
    assert property (@(posedge QnCPUCLK) disable iff (rst_i) push |-> !full);
    assert property (@(posedge QnCPUCLK) disable iff (rst_i) pop |-> (wordCount != '0));

endmodule

//--- scsiPortSm.sv
`timescale 1ns/1ns

module scsiPortSm import sdmacPkg::*; (
    input  logic QnCPUCLK,
    input  logic rst_i,
    input  logic dmaEnable_i,
    input  logic dmaDir_i,
    input  logic dreq_i,
    input  logic canTakeByte_i,
    input  logic hasByte_i,
    input  byteT fifoByte_i,
    input  byteT pdata_i,
    output byteT pdata_o,
    output logic dack_o,
    output logic ior_o,
    output logic iow_o,
    output logic byteWr_o,
    output logic byteRd_o,
    output byteT byteIn_o
);

    scsiStateT state;
    logic      writeCycle; // FIFO to chip
    logic      startOk;

    // Nothing starts while the FIFO has no room or no data
    assign startOk = dreq_i & dmaEnable_i & (dmaDir_i ? hasByte_i : canTakeByte_i);

    always_ff @(posedge QnCPUCLK) begin
        if (rst_i) begin
            state      <= SCSI_IDLE;
            writeCycle <= 1'b0;
            byteWr_o   <= 1'b0;
        end else begin
            byteWr_o <= 1'b0;
            case (state)
                SCSI_IDLE: begin
                    if (startOk) begin
                        state      <= SCSI_STROBE1;
                        writeCycle <= dmaDir_i;
                    end
                end
                SCSI_STROBE1: state <= SCSI_STROBE2;
                SCSI_STROBE2: begin
                    state    <= SCSI_RECOVER;
                    byteWr_o <= ~writeCycle; // Pushes the byte during recovery
                end
                SCSI_RECOVER: state <= SCSI_IDLE;
                default:      state <= SCSI_IDLE;
            endcase
        end
    end

    // Outgoing byte is held for both strobes, incoming is taken at the end of the second
    always_ff @(posedge QnCPUCLK) begin
        if (state == SCSI_IDLE && startOk) pdata_o <= fifoByte_i;
        if (state == SCSI_STROBE2) byteIn_o <= pdata_i;
    end

    assign dack_o   = (state == SCSI_STROBE1) || (state == SCSI_STROBE2);
    assign ior_o    = dack_o & ~writeCycle;
    assign iow_o    = dack_o & writeCycle;
    assign byteRd_o = (state == SCSI_RECOVER) & writeCycle; // Advance lane after the cycle

    assert property (@(posedge QnCPUCLK) disable iff (rst_i) !(ior_o && iow_o));

endmodule

//--- busMasterSm.sv
`timescale 1ns/1ns

module busMasterSm import sdmacPkg::*; (
    input  logic     QnCPUCLK,
    input  logic     rst_i,
    input  logic     startPulse_i,
    input  logic     dmaDir_i,
    input  dataWordT startAddr_i,
    input  countT    startCount_i,
    input  logic     hasWord_i,
    input  logic     hasSpaceWord_i,
    input  dataWordT wordOut_i,
    output logic     br_o,
    input  logic     bg_i,
    output logic     bgack_o,
    output logic     memAs_o,
    output logic     memRw_o,
    output dataWordT memAddr_o,
    output dataWordT memWdata_o,
    input  dataWordT memRdata_i,
    input  logic     memAck_i,
    input  logic     memBerr_i,
    output logic     wordWr_o,
    output logic     wordRd_o,
    output dataWordT wordIn_o,
    output logic     done_o,
    output logic     busError_o,
    output logic     busy_o
);

    busStateT state;
    countT    remaining;  // Bytes still to move
    logic     active;
    logic     wordReady;
    logic     wordAck;
    logic     lastWord;

    // Memory to SCSI needs room for a word, SCSI to memory needs a full one
    assign wordReady = dmaDir_i ? hasSpaceWord_i : hasWord_i;
    assign wordAck   = (state == BUS_STROBE) & memAck_i & ~memBerr_i;
    assign lastWord  = (remaining == countT'(4));

    always_ff @(posedge QnCPUCLK) begin
        if (rst_i) begin
            state     <= BUS_IDLE;
            active    <= 1'b0;
            remaining <= '0;
            memAddr_o <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= wordAck & lastWord;
            if (startPulse_i) begin
                memAddr_o <= startAddr_i;
                remaining <= startCount_i;
                active    <= (startCount_i != '0);
            end else if (wordAck) begin
                memAddr_o <= memAddr_o + dataWordT'(4);
                remaining <= remaining - countT'(4);
                if (lastWord) active <= 1'b0;
            end else if (state == BUS_ERROR) begin
                active <= 1'b0; // Transfer abandoned
            end

            case (state)
                BUS_IDLE:    if (active && wordReady) state <= BUS_REQUEST;
                BUS_REQUEST: if (bg_i) state <= BUS_OWN;
                BUS_OWN:     state <= (active && wordReady) ? BUS_STROBE : BUS_RELEASE;
                BUS_STROBE: begin
                    if (memBerr_i)
                        state <= BUS_ERROR;
                    else if (memAck_i)
                        state <= BUS_OWN;
                end
                BUS_RELEASE: state <= BUS_IDLE;
                BUS_ERROR:   state <= BUS_IDLE;
                default:     state <= BUS_IDLE;
            endcase
        end
    end

    // FIFO head is stable while the bus is held
    always_ff @(posedge QnCPUCLK) begin
        if (state == BUS_OWN) memWdata_o <= wordOut_i;
    end

    assign br_o       = (state == BUS_REQUEST);
    assign bgack_o    = (state == BUS_OWN) || (state == BUS_STROBE);
    assign memAs_o    = (state == BUS_STROBE);
    assign memRw_o    = dmaDir_i;   // High reads memory
    assign wordWr_o   = wordAck & dmaDir_i;
    assign wordRd_o   = wordAck & ~dmaDir_i;
    assign wordIn_o   = memRdata_i;
    assign busError_o = (state == BUS_ERROR);
    assign busy_o     = active || (state != BUS_IDLE);

    assert property (@(posedge QnCPUCLK) disable iff (rst_i) memAs_o |-> bgack_o);

endmodule

//--- sdmacTop.sv
`timescale 1ns/1ns
`include "sdmac_params.svh"

module sdmacTop import sdmacPkg::*; (
    input  logic     QnCPUCLK,
    input  logic     rst_i,
    // Host register port
    input  logic     regCs_i,
    input  logic     regWr_i,
    input  regAddrT  regAddr_i,
    input  dataWordT regWdata_i,
    output dataWordT regRdata_o,
    output logic     regAck_o,
    output logic     int_o,
    // System bus master
    output logic     br_o,
    input  logic     bg_i,
    output logic     bgack_o,
    output logic     memAs_o,
    output logic     memRw_o,
    output dataWordT memAddr_o,
    output dataWordT memWdata_o,
    input  dataWordT memRdata_i,
    input  logic     memAck_i,
    input  logic     memBerr_i,
    // WD33C93 side
    input  logic     scsiInt_i,
    input  logic     dreq_i,
    output logic     dack_o,
    output logic     ior_o,
    output logic     iow_o,
    input  byteT     pdata_i,
    output byteT     pdata_o
);

    logic     dmaEnable;
    logic     dmaDir;
    logic     startPulse;
    logic     done;
    logic     busError;
    logic     busy;
    logic     fifoEmpty;
    dataWordT startAddr;
    countT    startCount;
    logic     byteWr;
    logic     byteRd;
    logic     wordWr;
    logic     wordRd;
    byteT     byteIn;
    byteT     fifoByte;
    dataWordT wordIn;
    dataWordT wordOut;
    logic     canTakeByte;
    logic     hasByte;
    logic     hasWord;
    logic     hasSpaceWord;

    sdmacRegisters sdmacRegisters_i (
        .QnCPUCLK     (QnCPUCLK),
        .rst_i        (rst_i),
        .regCs_i      (regCs_i),
        .regWr_i      (regWr_i),
        .regAddr_i    (regAddr_i),
        .regWdata_i   (regWdata_i),
        .regRdata_o   (regRdata_o),
        .regAck_o     (regAck_o),
        .scsiInt_i    (scsiInt_i),
        .done_i       (done),
        .busError_i   (busError),
        .fifoEmpty_i  (fifoEmpty),
        .busy_i       (busy),
        .dmaEnable_o  (dmaEnable),
        .dmaDir_o     (dmaDir),
        .startAddr_o  (startAddr),
        .startCount_o (startCount),
        .startPulse_o (startPulse),
        .int_o        (int_o)
    );

    // A new transfer starts from an empty FIFO
    dmaFifo #(
        .Depth (`SDMAC_FIFO_DEPTH)
    ) dmaFifo_i (
        .QnCPUCLK       (QnCPUCLK),
        .rst_i          (rst_i),
        .clear_i        (startPulse),
        .byteWr_i       (byteWr),
        .byteIn_i       (byteIn),
        .byteRd_i       (byteRd),
        .byteOut_o      (fifoByte),
        .wordWr_i       (wordWr),
        .wordIn_i       (wordIn),
        .wordRd_i       (wordRd),
        .wordOut_o      (wordOut),
        .canTakeByte_o  (canTakeByte),
        .hasByte_o      (hasByte),
        .hasWord_o      (hasWord),
        .hasSpaceWord_o (hasSpaceWord),
        .empty_o        (fifoEmpty)
    );

    scsiPortSm scsiPortSm_i (
        .QnCPUCLK      (QnCPUCLK),
        .rst_i         (rst_i),
        .dmaEnable_i   (dmaEnable),
        .dmaDir_i      (dmaDir),
        .dreq_i        (dreq_i),
        .canTakeByte_i (canTakeByte),
        .hasByte_i     (hasByte),
        .fifoByte_i    (fifoByte),
        .pdata_i       (pdata_i),
        .pdata_o       (pdata_o),
        .dack_o        (dack_o),
        .ior_o         (ior_o),
        .iow_o         (iow_o),
        .byteWr_o      (byteWr),
        .byteRd_o      (byteRd),
        .byteIn_o      (byteIn)
    );

    busMasterSm busMasterSm_i (
        .QnCPUCLK       (QnCPUCLK),
        .rst_i          (rst_i),
        .startPulse_i   (startPulse),
        .dmaDir_i       (dmaDir),
        .startAddr_i    (startAddr),
        .startCount_i   (startCount),
        .hasWord_i      (hasWord),
        .hasSpaceWord_i (hasSpaceWord),
        .wordOut_i      (wordOut),
        .br_o           (br_o),
        .bg_i           (bg_i),
        .bgack_o        (bgack_o),
        .memAs_o        (memAs_o),
        .memRw_o        (memRw_o),
        .memAddr_o      (memAddr_o),
        .memWdata_o     (memWdata_o),
        .memRdata_i     (memRdata_i),
        .memAck_i       (memAck_i),
        .memBerr_i      (memBerr_i),
        .wordWr_o       (wordWr),
        .wordRd_o       (wordRd),
        .wordIn_o       (wordIn),
        .done_o         (done),
        .busError_o     (busError),
        .busy_o         (busy)
    );

endmodule

//--- tbClockGen.sv
`timescale 1ns/1ns

module tbClockGen (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #5 clk_o = ~clk_o; // 10 ns period

endmodule

//--- sdmacTb.sv
`timescale 1ns/1ns
`include "sdmac_params.svh"

module sdmacTb import sdmacPkg::*; ();

    logic     QnCPUCLK;
    logic     rst_i;
    logic     regCs;
    logic     regWr;
    regAddrT  regAddr;
    dataWordT regWdata;
    dataWordT regRdata;
    logic     regAck;
    logic     intOut;
    logic     br;
    logic     bg;
    logic     bgack;
    logic     memAs;
    logic     memRw;
    dataWordT memAddr;
    dataWordT memWdata;
    dataWordT memRdata;
    logic     memAck;
    logic     memBerr;
    logic     scsiInt;
    logic     dreq;
    logic     dack;
    logic     ior;
    logic     iow;
    byteT     pdataIn;
    byteT     pdataOut;

    integer   seed = 84399;
    int       delayMask;       // Upper bound mask for model delays
    bit       berrMode;        // Memory answers with a bus error
    int       wordsWritten;
    int       gp;              // Read pointer into the golden data
    int       grantDelay;
    int       ackDelay;
    dataWordT cycAddr;
    dataWordT cycData;
    logic     cycRead;
    dataWordT memModel [dataWordT];
    dataWordT golden [0:255];

    tbClockGen tbClockGen_i (.clk_o(QnCPUCLK));

    sdmacTop sdmacTop_i (
        .QnCPUCLK   (QnCPUCLK),
        .rst_i      (rst_i),
        .regCs_i    (regCs),
        .regWr_i    (regWr),
        .regAddr_i  (regAddr),
        .regWdata_i (regWdata),
        .regRdata_o (regRdata),
        .regAck_o   (regAck),
        .int_o      (intOut),
        .br_o       (br),
        .bg_i       (bg),
        .bgack_o    (bgack),
        .memAs_o    (memAs),
        .memRw_o    (memRw),
        .memAddr_o  (memAddr),
        .memWdata_o (memWdata),
        .memRdata_i (memRdata),
        .memAck_i   (memAck),
        .memBerr_i  (memBerr),
        .scsiInt_i  (scsiInt),
        .dreq_i     (dreq),
        .dack_o     (dack),
        .ior_o      (ior),
        .iow_o      (iow),
        .pdata_i    (pdataIn),
        .pdata_o    (pdataOut)
    );

    task automatic stopRun();
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic checkValue(input string name, input dataWordT expected,
                              input dataWordT actual);
        assert (actual === expected) else begin
            $display("error %s expected %h actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out waiting for %s", what);
        stopRun();
    endtask

    // One host cycle, chip select held until the acknowledge shows up
    task automatic regAccess(input logic wr, input regAddrT addr, input dataWordT wdata,
                             output dataWordT rdata);
        int cycles;
        @(posedge QnCPUCLK);
        regCs    <= 1'b1;
        regWr    <= wr;
        regAddr  <= addr;
        regWdata <= wdata;
        cycles = 0;
        do begin
            @(negedge QnCPUCLK);
            cycles++;
        end while (!regAck && cycles < 20);
        if (!regAck) timeoutFail("regAck_o");
        // Select is sampled on the first edge, the ack follows one cycle later
        assert (cycles == 2) else begin
            $display("Register access was not acknowledged one cycle after select");
            stopRun();
        end
        rdata = regRdata;
        @(posedge QnCPUCLK);
        regCs <= 1'b0;
        regWr <= 1'b0;
    endtask

    task automatic writeReg(input regAddrT addr, input dataWordT wdata);
        dataWordT unused;
        regAccess(1'b1, addr, wdata, unused);
    endtask

    task automatic readReg(input regAddrT addr, output dataWordT rdata);
        regAccess(1'b0, addr, '0, rdata);
    endtask

    // Bus arbiter, grant after a random delay
    always begin
        @(negedge QnCPUCLK);
        if (br === 1'b1 && !bg) begin
            grantDelay = $random(seed) & delayMask;
            repeat (grantDelay) @(posedge QnCPUCLK);
            @(posedge QnCPUCLK);
            bg <= 1'b1;
        end else if (br !== 1'b1 && bg) begin
            @(posedge QnCPUCLK);
            bg <= 1'b0;
        end
    end

    // Memory slave with a random acknowledge delay
    always begin
        @(negedge QnCPUCLK);
        if (memAs === 1'b1 && !memAck && !memBerr) begin
            cycAddr  = memAddr;
            cycData  = memWdata;
            cycRead  = memRw;
            ackDelay = $random(seed) & delayMask;
            repeat (ackDelay) @(posedge QnCPUCLK);
            @(posedge QnCPUCLK);
            if (berrMode) begin
                memBerr <= 1'b1;
            end else begin
                memAck <= 1'b1;
                if (cycRead) begin
                    memRdata <= memModel.exists(cycAddr) ? memModel[cycAddr] : ~cycAddr;
                end else begin
                    memModel[cycAddr] = cycData;
                    wordsWritten++;
                end
            end
            @(posedge QnCPUCLK);
            memAck  <= 1'b0;
            memBerr <= 1'b0;
        end
    end

    always @(negedge QnCPUCLK) begin
        if (!rst_i) begin
            assert (!(ior && iow)) else begin
                $display("ior_o and iow_o were high in the same cycle");
                stopRun();
            end
        end
    end

    // WD33C93 model, one DREQ per byte
    task automatic runChip(input logic outbound, input int first, input int nBytes);
        int delay;
        int waited;
        int strobes;
        for (int i = 0; i < nBytes; i++) begin
            delay = $random(seed) & delayMask;
            repeat (delay) @(posedge QnCPUCLK);
            @(posedge QnCPUCLK);
            dreq <= 1'b1;
            if (!outbound) pdataIn <= golden[first + i][7:0];
            waited = 0;
            do begin
                @(negedge QnCPUCLK);
                waited++;
            end while (!dack && waited < 300);
            if (!dack) timeoutFail("dack_o");
            strobes = 0;
            while (dack && strobes < 3) begin
                strobes++;
                if (outbound) begin
                    checkValue("iow_o", 1, iow);
                    checkValue("pdata_o", golden[first + i][7:0], pdataOut);
                end else begin
                    checkValue("ior_o", 1, ior);
                end
                @(posedge QnCPUCLK);
                dreq <= 1'b0;
                @(negedge QnCPUCLK);
            end
            checkValue("dack_o cycles", 2, strobes);
        end
    endtask

    task automatic runTransfer();
        dataWordT dir;
        dataWordT addr;
        dataWordT status;
        int       nBytes;
        int       firstByte;
        int       firstWord;
        int       polls;
        bit       finished;
        dir       = golden[gp];
        berrMode  = golden[gp + 1][0];
        addr      = golden[gp + 2];
        nBytes    = golden[gp + 3];
        delayMask = golden[gp + 4];
        firstByte = gp + 5;
        firstWord = firstByte + nBytes;
        gp        = firstWord + nBytes / 4;
        wordsWritten = 0;
        if (dir[0]) begin
            for (int i = 0; i < nBytes / 4; i++) memModel[addr + 4 * i] = golden[firstWord + i];
        end
        writeReg(`REG_ADDRESS, addr);
        writeReg(`REG_COUNT, nBytes);
        writeReg(`REG_CONTROL, {29'd0, 1'b1, dir[0], 1'b1}); // Interrupt on, start
        runChip(dir[0], firstByte, nBytes);
        polls = 0;
        do begin
            readReg(`REG_STATUS, status);
            finished = berrMode ? status[1] : !status[4];
            polls++;
        end while (!finished && polls < 200);
        if (!finished) timeoutFail("the end of the transfer");
        @(negedge QnCPUCLK);
        checkValue("int_o", 1, intOut);
        if (berrMode) begin
            checkValue("bgack_o", 0, bgack);
            checkValue("STATUS done", 0, status[0]);
        end else begin
            checkValue("STATUS done", 1, status[0]);
            if (!dir[0]) begin
                checkValue("word writes", nBytes / 4, wordsWritten);
                for (int i = 0; i < nBytes / 4; i++) begin
                    checkValue("memory word", golden[firstWord + i],
                               memModel.exists(addr + 4 * i) ? memModel[addr + 4 * i] : 'x);
                end
            end
        end
        writeReg(`REG_ISTR_CLR, '0);
        @(negedge QnCPUCLK);
        checkValue("int_o", 0, intOut);
    endtask

    initial begin : mainFlow
        dataWordT rd;
        rst_i    = 1'b1;
        regCs    = 1'b0;
        regWr    = 1'b0;
        regAddr  = '0;
        regWdata = '0;
        bg       = 1'b0;
        memRdata = '0;
        memAck   = 1'b0;
        memBerr  = 1'b0;
        scsiInt  = 1'b0;
        dreq     = 1'b0;
        pdataIn  = '0;
        berrMode = 1'b0;
        delayMask = 0;
        $readmemh("sdmacGolden.txt", golden);
        if (golden[0] === 'x) begin
            $display("The golden data file could not be read");
            stopRun();
        end
        repeat (8) @(posedge QnCPUCLK);
        rst_i <= 1'b0;

        writeReg(`REG_ADDRESS, 32'h1234_5678);
        writeReg(`REG_COUNT, 32'h00ab_cdec);
        writeReg(`REG_CONTROL, 32'h0000_0006); // Enable stays off
        readReg(`REG_ADDRESS, rd);
        checkValue("ADDRESS", 32'h1234_5678, rd);
        readReg(`REG_COUNT, rd);
        checkValue("COUNT", 32'h00ab_cdec, rd);
        readReg(`REG_CONTROL, rd);
        checkValue("CONTROL", 32'h0000_0006, rd);

        gp = 0;
        while (golden[gp] !== 32'hffff_ffff && gp < 240) runTransfer();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- sdmacGolden.txt
// Record: dir (1 = memory to SCSI), berr, address, byte count, delay mask
// then the port bytes in order, then the memory words; ffffffff ends the list
0 0 00001000 8 0
11 22 33 44 55 66 77 88
11223344 55667788
1 0 00002000 8 0
a1 b2 c3 d4 e5 f6 07 18
a1b2c3d4 e5f60718
0 0 00003000 14 7
01 02 03 04 05 06 07 08 09 0a
0b 0c 0d 0e 0f 10 11 12 13 14
01020304 05060708 090a0b0c 0d0e0f10 11121314
1 0 00004000 10 7
de ad be ef ca fe ba be
0f 1e 2d 3c 4b 5a 69 78
deadbeef cafebabe 0f1e2d3c 4b5a6978
0 1 00005000 8 3
5a a5 3c c3 96 69 f0 0f
5aa53cc3 9669f00f
ffffffff

//--- tb.f
+incdir+.
sdmacPkg.sv
sdmacRegisters.sv
dmaFifo.sv
scsiPortSm.sv
busMasterSm.sv
sdmacTop.sv
tbClockGen.sv
sdmacTb.sv

//--- Bender.yml
package:
  name: sdmac

sources:
  - include_dirs:
      - .
    files:
      - sdmacPkg.sv
      - sdmacRegisters.sv
      - dmaFifo.sv
      - scsiPortSm.sv
      - busMasterSm.sv
      - sdmacTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClockGen.sv
      - sdmacTb.sv
